// File: bench/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model import mem_pkg::*; #(
  parameter word_t       PATTERN = 64'h0,
  parameter int          LATENCY = 4,
  parameter logic [31:0] SEED    = 32'h1
) (
  input  logic         clock,
  input  logic         reset,
  input  logic         rejects_en,   // Random rejects, about one in four
  input  logic         reject_all,   // Holds the bus off completely
  input  bus_command_e proc2mem_command,
  input  addr_t        proc2mem_addr,
  input  word_t        proc2mem_data,
  output mem_tag_t     mem2proc_response,
  output word_t        mem2proc_data,
  output mem_tag_t     mem2proc_tag
);

  localparam int MEM_WORDS = 1024;

  word_t    mem [MEM_WORDS];
  mem_tag_t ret_tag [LATENCY];
  word_t    ret_data [LATENCY];
  mem_tag_t next_tag;
  logic     reject_now;
  logic     accept;
  logic [9:0] word_idx;
  integer   seed;

  assign word_idx          = proc2mem_addr[12:3];
  assign accept            = (proc2mem_command != BUS_NONE) && !reject_now && !reject_all;
  assign mem2proc_response = accept ? next_tag : '0;
  assign mem2proc_tag      = ret_tag[LATENCY-1];
  assign mem2proc_data     = ret_data[LATENCY-1];

  initial begin
    seed = SEED;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = (word_t'(i) << 3) ^ PATTERN;  // Address XOR constant
    end
  end

  always @(posedge clock) begin
    if (reset) begin
      next_tag   <= mem_tag_t'(1);
      reject_now <= 1'b0;
      for (int i = 0; i < LATENCY; i++) begin
        ret_tag[i]  <= '0;
        ret_data[i] <= '0;
      end
    end else begin
      reject_now <= rejects_en && (($random(seed) & 32'd3) == 32'd0);
      for (int i = LATENCY - 1; i > 0; i--) begin
        ret_tag[i]  <= ret_tag[i-1];
        ret_data[i] <= ret_data[i-1];
      end
      ret_tag[0]  <= '0;
      ret_data[0] <= '0;
      if (accept) begin
        next_tag <= (next_tag == 4'hf) ? mem_tag_t'(1) : next_tag + mem_tag_t'(1);
        if (proc2mem_command == BUS_LOAD) begin
          ret_tag[0]  <= next_tag;
          ret_data[0] <= mem[word_idx];
        end else begin
          mem[word_idx] <= proc2mem_data;  // Store done on accept
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/tb_mem_front.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_front import mem_pkg::*; ();

  localparam int          QUEUE_DEPTH = 4;
  localparam word_t       PATTERN     = 64'hc3a5_0f96_5a3c_e187;
  localparam logic [31:0] SEED        = 32'h7059_3466;
  localparam int          TIMEOUT     = 200;  // Cycles per wait
  localparam addr_t       FETCH_BASE  = 64'h1000;

  logic         clock;
  logic         reset;
  logic         fetch_req;
  fetch_req_t   fetch_addr;
  logic         fetch_ack;
  word_t        fetch_data;
  logic         data_req;
  data_req_t    data_cmd;
  logic         data_ack;
  word_t        load_data;
  bus_command_e proc2mem_command;
  addr_t        proc2mem_addr;
  word_t        proc2mem_data;
  mem_tag_t     mem2proc_response;
  word_t        mem2proc_data;
  mem_tag_t     mem2proc_tag;
  logic         rejects_en;
  logic         reject_all;

  integer seed;
  string  test_name;
  int     check_count;
  int     error_count;
  int     test_checks;
  int     test_errors;
  logic   fetch_pending;
  logic   load_pending;
  word_t  fetch_expected;
  word_t  load_expected;
  word_t  stored_words [addr_t];
  event   timeout_seen;

  mem_front_top #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) i_dut (
    .clock             (clock),
    .reset             (reset),
    .fetch_req         (fetch_req),
    .fetch_addr        (fetch_addr),
    .fetch_ack         (fetch_ack),
    .fetch_data        (fetch_data),
    .data_req          (data_req),
    .data_cmd          (data_cmd),
    .data_ack          (data_ack),
    .load_data         (load_data),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .proc2mem_data     (proc2mem_data),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag)
  );

  mem_model #(
    .PATTERN (PATTERN),
    .LATENCY (4),
    .SEED    (SEED)
  ) i_mem (
    .clock             (clock),
    .reset             (reset),
    .rejects_en        (rejects_en),
    .reject_all        (reject_all),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .proc2mem_data     (proc2mem_data),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // Last stored value or the initial memory pattern
  function automatic word_t expected_word(input addr_t addr);
    if (stored_words.exists(addr)) return stored_words[addr];
    return addr ^ PATTERN;
  endfunction

  // One compare per handshake while ack is high
  always @(negedge clock) begin
    if (fetch_ack && fetch_pending) begin
      fetch_pending = 1'b0;
      check_count++;
      assert (fetch_data == fetch_expected) else begin
        $display("Fail %s: fetch expected %h, actual %h", test_name, fetch_expected, fetch_data);
        error_count++;
      end
    end
    if (data_ack && load_pending) begin
      load_pending = 1'b0;
      check_count++;
      assert (load_data == load_expected) else begin
        $display("Fail %s: load expected %h, actual %h", test_name, load_expected, load_data);
        error_count++;
      end
    end
  end

  // Ends the run on the first timeout
  initial begin
    @(timeout_seen);
    $display("Testbench failed");
    $finish;
  end

  task report_timeout(input string what);
    $display("Timeout in %s: %s", test_name, what);
    -> timeout_seen;
  endtask

  task fetch_word(input addr_t addr);
    int waited;
    @(negedge clock);
    fetch_expected = expected_word(addr);
    fetch_pending  = 1'b1;
    fetch_addr     = '{addr: addr};
    fetch_req      = 1'b1;
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
    end while (!fetch_ack && waited < TIMEOUT);
    if (!fetch_ack) report_timeout("fetch ack never rose");
    fetch_req = 1'b0;
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
    end while (fetch_ack && waited < TIMEOUT);
    if (fetch_ack) report_timeout("fetch ack stuck high");
  endtask

  task data_access(input data_op_e op, input addr_t addr, input word_t data);
    int waited;
    @(negedge clock);
    if (op == DATA_LOAD) begin
      load_expected = expected_word(addr);
      load_pending  = 1'b1;
    end else begin
      stored_words[addr] = data;
    end
    data_cmd = '{op: op, addr: addr, data: data};
    data_req = 1'b1;
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
    end while (!data_ack && waited < TIMEOUT);
    if (!data_ack) report_timeout("data ack never rose");
    data_req = 1'b0;
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
    end while (data_ack && waited < TIMEOUT);
    if (data_ack) report_timeout("data ack stuck high");
  endtask

  task start_test(input string name);
    test_name   = name;
    test_checks = check_count;
    test_errors = error_count;
  endtask

  task end_test();
    $display("%s done: %0d checks, %0d errors", test_name,
             check_count - test_checks, error_count - test_errors);
  endtask

  initial begin
    addr_t addr;
    word_t data;
    int    kind;
    addr_t burst_addrs[$];

    seed          = SEED;
    reset         = 1'b1;
    fetch_req     = 1'b0;
    fetch_addr    = '0;
    data_req      = 1'b0;
    data_cmd      = '0;
    rejects_en    = 1'b0;
    reject_all    = 1'b0;
    fetch_pending = 1'b0;
    load_pending  = 1'b0;
    check_count   = 0;
    error_count   = 0;
    test_name     = "reset";
    repeat (5) @(negedge clock);
    reset = 1'b0;

    start_test("fetch_miss_hit");
    fetch_word(FETCH_BASE + 64'h40);
    fetch_word(FETCH_BASE + 64'h40);   // Hit
    fetch_word(FETCH_BASE + 64'h140);  // Same line index with another tag
    fetch_word(FETCH_BASE + 64'h40);
    end_test();

    start_test("store_load_forward");
    reject_all = 1'b1;  // Keeps the stores queued
    data_access(DATA_STORE, 64'h80, 64'h1111_2222_3333_4444);
    data_access(DATA_LOAD, 64'h80, '0);
    data_access(DATA_STORE, 64'h88, 64'h5555_6666_7777_8888);
    data_access(DATA_STORE, 64'h80, 64'h9999_aaaa_bbbb_cccc);
    data_access(DATA_LOAD, 64'h80, '0);  // Youngest match
    reject_all = 1'b0;
    data_access(DATA_LOAD, 64'h88, '0);
    end_test();

    start_test("store_burst");
    fork
      begin
        repeat (3 * QUEUE_DEPTH) begin
          addr = addr_t'(($random(seed) & 32'h1f) << 3);
          data = {$random(seed), $random(seed)};
          burst_addrs.push_back(addr);
          data_access(DATA_STORE, addr, data);
        end
      end
      begin
        @(negedge clock);
        reject_all = 1'b1;
        repeat (30) @(negedge clock);  // Long enough to fill the queue
        reject_all = 1'b0;
      end
    join
    foreach (burst_addrs[i]) data_access(DATA_LOAD, burst_addrs[i], '0);
    end_test();

    start_test("fetch_and_load");
    for (int n = 0; n < 3; n++) begin
      fork
        fetch_word(FETCH_BASE + addr_t'(64'h208 + n * 64'h100));
        data_access(DATA_LOAD, burst_addrs[n], '0);
      join
    end
    end_test();

    start_test("random_mix");
    rejects_en = 1'b1;
    for (int n = 0; n < 80; n++) begin
      kind = $random(seed) & 32'd3;
      if (kind == 0) begin
        addr = FETCH_BASE + addr_t'(($random(seed) & 32'h1ff) << 3);
        fetch_word(addr);
      end else if (kind == 1) begin
        addr = addr_t'(($random(seed) & 32'h1f) << 3);
        data_access(DATA_LOAD, addr, '0);
      end else begin
        addr = addr_t'(($random(seed) & 32'h1f) << 3);
        data = {$random(seed), $random(seed)};
        data_access(DATA_STORE, addr, data);
      end
    end
    rejects_en = 1'b0;
    end_test();

    @(negedge clock);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_front \
  -f sim.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"
if echo "$out" | grep -q "Testbench passed"; then
  exit 0
else
  exit 1
fi

// File: sim.f
src/mem_pkg.sv
src/icache_mem.sv
src/icache_ctrl.sv
src/dmem_store_queue.sv
src/mem_bus_arbiter.sv
src/mem_front_top.sv
bench/mem_model.sv
bench/tb_mem_front.sv

// File: src/dmem_store_queue.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_store_queue import mem_pkg::*; #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic      clock,
  input  logic      reset,
  input  logic      data_req,
  input  data_req_t data_cmd,
  output logic      data_ack,
  output word_t     load_data,
  output bus_req_t  bus_req,
  input  bus_rsp_t  bus_rsp
);

  localparam int PTR_BITS = $clog2(QUEUE_DEPTH);

  typedef enum logic [2:0] {
    IDLE,
    DRAIN_WAIT,
    LOAD_ISSUE,
    LOAD_WAIT,
    ACK
  } data_state_e;

  data_state_e         state;
  addr_t               sq_addr [QUEUE_DEPTH];
  word_t               sq_data [QUEUE_DEPTH];
  logic [PTR_BITS-1:0] head;
  logic [PTR_BITS-1:0] tail;
  logic [PTR_BITS:0]   count;
  mem_tag_t            load_tag;
  logic                is_load;
  logic                queue_empty;
  logic                queue_full;
  logic                enqueue;
  logic                dequeue;
  logic                fwd_hit;
  word_t               fwd_data;
  logic                load_fwd;
  logic                load_return;

  assign is_load     = (data_cmd.op == DATA_LOAD);
  assign queue_empty = (count == '0);
  assign queue_full  = (count == (PTR_BITS + 1)'(QUEUE_DEPTH));
  assign enqueue     = (state == IDLE) && data_req && !is_load && !queue_full;
  assign dequeue     = !queue_empty && (bus_rsp.response != '0);  // Head store accepted
  assign load_fwd    = (state == IDLE) && data_req && is_load && fwd_hit;
  assign load_return = (state == LOAD_WAIT) && (bus_rsp.tag == load_tag);
  assign data_ack    = (state == ACK);

  // Queued stores go first, a load is only issued on an empty queue
  always_comb begin
    bus_req.command = BUS_NONE;
    bus_req.addr    = sq_addr[head];
    bus_req.data    = sq_data[head];
    if (!queue_empty) begin
      bus_req.command = BUS_STORE;
    end else if (state == LOAD_ISSUE) begin
      bus_req.command = BUS_LOAD;
      bus_req.addr    = data_cmd.addr;
    end
  end

  // Oldest to youngest, so the youngest match wins
  always_comb begin
    logic [PTR_BITS-1:0] slot;
    fwd_hit  = 1'b0;
    fwd_data = '0;
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      slot = head + PTR_BITS'(i);
      if (i < count && sq_addr[slot] == data_cmd.addr) begin
        fwd_hit  = 1'b1;
        fwd_data = sq_data[slot];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (enqueue) tail <= tail + 1'b1;
      if (dequeue) head <= head + 1'b1;
      case ({enqueue, dequeue})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (enqueue) begin
      sq_addr[tail] <= data_cmd.addr;
      sq_data[tail] <= data_cmd.data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= IDLE;
      load_tag <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (enqueue || load_fwd) begin
            state <= ACK;
          end else if (data_req && is_load) begin
            state <= DRAIN_WAIT;
          end
        end
        DRAIN_WAIT: if (queue_empty) state <= LOAD_ISSUE;
        LOAD_ISSUE: begin
          if (bus_rsp.response != '0) begin
            load_tag <= bus_rsp.response;
            state    <= LOAD_WAIT;
          end
        end
        LOAD_WAIT:  if (load_return) state <= ACK;
        ACK:        if (!data_req) state <= IDLE;
        default:    state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (load_fwd) begin
      load_data <= fwd_data;
    end else if (load_return) begin
      load_data <= bus_rsp.data;
    end
  end

endmodule

`default_nettype wire

// File: src/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl import mem_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       fetch_req,
  input  fetch_req_t fetch_addr,
  output logic       fetch_ack,
  output word_t      fetch_data,
  output bus_req_t   bus_req,
  input  bus_rsp_t   bus_rsp
);

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    MISS_ISSUE,
    MISS_WAIT,
    DONE
  } fetch_state_e;

  fetch_state_e               state;
  mem_tag_t                   miss_tag;
  logic [ICACHE_IDX_BITS-1:0] line_idx;
  logic [ICACHE_TAG_BITS-1:0] line_tag;
  word_t                      cache_data;
  logic                       cache_hit;
  logic                       fill_en;

  // Address held stable by the requester until ack
  assign line_idx = fetch_addr.addr[WORD_OFFSET_BITS +: ICACHE_IDX_BITS];
  assign line_tag = fetch_addr.addr[WORD_OFFSET_BITS + ICACHE_IDX_BITS +: ICACHE_TAG_BITS];

  assign fill_en   = (state == MISS_WAIT) && (bus_rsp.tag == miss_tag);
  assign fetch_ack = (state == DONE);

  assign bus_req = '{
    command: (state == MISS_ISSUE) ? BUS_LOAD : BUS_NONE,
    addr:    fetch_addr.addr,
    data:    '0
  };

  icache_mem icache_mem_0 (
    .clock   (clock),
    .reset   (reset),
    .rd_idx  (line_idx),
    .rd_tag  (line_tag),
    .rd_data (cache_data),
    .rd_hit  (cache_hit),
    .wr_en   (fill_en),
    .wr_idx  (line_idx),
    .wr_tag  (line_tag),
    .wr_data (bus_rsp.data)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= IDLE;
      miss_tag <= '0;
    end else begin
      case (state)
        IDLE:       if (fetch_req) state <= LOOKUP;
        LOOKUP:     state <= cache_hit ? DONE : MISS_ISSUE;
        MISS_ISSUE: begin
          if (bus_rsp.response != '0) begin  // Accepted, else keep bidding
            miss_tag <= bus_rsp.response;
            state    <= MISS_WAIT;
          end
        end
        MISS_WAIT:  if (fill_en) state <= DONE;
        DONE:       if (!fetch_req) state <= IDLE;
        default:    state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == LOOKUP && cache_hit) begin
      fetch_data <= cache_data;
    end else if (fill_en) begin
      fetch_data <= bus_rsp.data;  // Same word that fills the line
    end
  end

endmodule

`default_nettype wire

// File: src/icache_mem.sv
`timescale 1ns/1ps
`default_nettype none

module icache_mem import mem_pkg::*; (
  input  logic                       clock,
  input  logic                       reset,
  input  logic [ICACHE_IDX_BITS-1:0] rd_idx,
  input  logic [ICACHE_TAG_BITS-1:0] rd_tag,
  output word_t                      rd_data,
  output logic                       rd_hit,
  input  logic                       wr_en,
  input  logic [ICACHE_IDX_BITS-1:0] wr_idx,
  input  logic [ICACHE_TAG_BITS-1:0] wr_tag,
  input  word_t                      wr_data
);

  localparam int NUM_LINES = 1 << ICACHE_IDX_BITS;

  logic [NUM_LINES-1:0]       line_valid;
  logic [ICACHE_TAG_BITS-1:0] line_tag  [NUM_LINES];
  word_t                      line_data [NUM_LINES];

  assign rd_data = line_data[rd_idx];
  assign rd_hit  = line_valid[rd_idx] && (line_tag[rd_idx] == rd_tag);

  always_ff @(posedge clock) begin
    if (reset) begin
      line_valid <= '0;
    end else if (wr_en) begin
      line_valid[wr_idx] <= 1'b1;
    end
  end

  // Tag and data arrays
  always_ff @(posedge clock) begin
    if (wr_en) begin
      line_tag[wr_idx]  <= wr_tag;
      line_data[wr_idx] <= wr_data;
    end
  end

endmodule

`default_nettype wire

// File: src/mem_bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_bus_arbiter import mem_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  bus_req_t     icache_bus,
  input  bus_req_t     dmem_bus,
  output bus_rsp_t     icache_rsp,
  output bus_rsp_t     dmem_rsp,
  output bus_command_e proc2mem_command,
  output addr_t        proc2mem_addr,
  output word_t        proc2mem_data,
  input  mem_tag_t     mem2proc_response,
  input  word_t        mem2proc_data,
  input  mem_tag_t     mem2proc_tag
);

  logic                    dmem_sel;
  logic [NUM_MEM_TAGS-1:0] tag_busy;
  logic [NUM_MEM_TAGS-1:0] tag_dmem;  // Owner of each open load tag
  logic                    load_accept;
  logic                    tag_return;
  logic                    to_icache;
  logic                    to_dmem;

  assign dmem_sel = (dmem_bus.command != BUS_NONE);  // Data side has priority

  assign proc2mem_command = dmem_sel ? dmem_bus.command : icache_bus.command;
  assign proc2mem_addr    = dmem_sel ? dmem_bus.addr : icache_bus.addr;
  assign proc2mem_data    = dmem_sel ? dmem_bus.data : icache_bus.data;

  assign load_accept = (proc2mem_command == BUS_LOAD) && (mem2proc_response != '0);
  assign tag_return  = (mem2proc_tag != '0) && tag_busy[mem2proc_tag];
  assign to_icache   = tag_return && !tag_dmem[mem2proc_tag];
  assign to_dmem     = tag_return && tag_dmem[mem2proc_tag];

  assign icache_rsp = '{
    response: dmem_sel ? '0 : mem2proc_response,
    tag:      to_icache ? mem2proc_tag : '0,
    data:     to_icache ? mem2proc_data : '0
  };

  assign dmem_rsp = '{
    response: dmem_sel ? mem2proc_response : '0,
    tag:      to_dmem ? mem2proc_tag : '0,
    data:     to_dmem ? mem2proc_data : '0
  };

  always_ff @(posedge clock) begin
    if (reset) begin
      tag_busy <= '0;
    end else begin
      if (tag_return) tag_busy[mem2proc_tag] <= 1'b0;
      if (load_accept) tag_busy[mem2proc_response] <= 1'b1;  // Reuse wins over clear
    end
  end

  always_ff @(posedge clock) begin
    if (load_accept) tag_dmem[mem2proc_response] <= dmem_sel;
  end

endmodule

`default_nettype wire

// File: src/mem_front_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_front_top import mem_pkg::*; #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic         clock,
  input  logic         reset,
  input  logic         fetch_req,          // Instruction port
  input  fetch_req_t   fetch_addr,
  output logic         fetch_ack,
  output word_t        fetch_data,
  input  logic         data_req,           // Data port
  input  data_req_t    data_cmd,
  output logic         data_ack,
  output word_t        load_data,
  output bus_command_e proc2mem_command,
  output addr_t        proc2mem_addr,
  output word_t        proc2mem_data,
  input  mem_tag_t     mem2proc_response,
  input  word_t        mem2proc_data,
  input  mem_tag_t     mem2proc_tag
);

  bus_req_t icache_bus;
  bus_req_t dmem_bus;
  bus_rsp_t icache_rsp;
  bus_rsp_t dmem_rsp;

  icache_ctrl icache_ctrl_0 (
    .clock      (clock),
    .reset      (reset),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .fetch_ack  (fetch_ack),
    .fetch_data (fetch_data),
    .bus_req    (icache_bus),
    .bus_rsp    (icache_rsp)
  );

  dmem_store_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) dmem_sq_0 (
    .clock     (clock),
    .reset     (reset),
    .data_req  (data_req),
    .data_cmd  (data_cmd),
    .data_ack  (data_ack),
    .load_data (load_data),
    .bus_req   (dmem_bus),
    .bus_rsp   (dmem_rsp)
  );

  mem_bus_arbiter arbiter_0 (
    .clock             (clock),
    .reset             (reset),
    .icache_bus        (icache_bus),
    .dmem_bus          (dmem_bus),
    .icache_rsp        (icache_rsp),
    .dmem_rsp          (dmem_rsp),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .proc2mem_data     (proc2mem_data),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag)
  );

endmodule

`default_nettype wire

// File: src/mem_pkg.sv
`default_nettype none

package mem_pkg;

  localparam int MEM_TAG_BITS     = 4;
  localparam int NUM_MEM_TAGS     = 1 << MEM_TAG_BITS;
  localparam int WORD_OFFSET_BITS = 3;  // 8-byte words
  localparam int ICACHE_IDX_BITS  = 5;
  localparam int ICACHE_TAG_BITS  = 8;

  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_command_e;

  typedef logic [MEM_TAG_BITS-1:0] mem_tag_t;  // Zero means no transaction
  typedef logic [63:0]             addr_t;
  typedef logic [63:0]             word_t;

  typedef enum logic [0:0] {
    DATA_LOAD  = 1'b0,
    DATA_STORE = 1'b1
  } data_op_e;

  typedef struct packed {
    addr_t addr;
  } fetch_req_t;

  typedef struct packed {
    data_op_e op;
    addr_t    addr;
    word_t    data;
  } data_req_t;

  // One side's bid for the memory bus
  typedef struct packed {
    bus_command_e command;
    addr_t        addr;
    word_t        data;
  } bus_req_t;

  typedef struct packed {
    mem_tag_t response;  // Accept tag, only to the winner
    mem_tag_t tag;       // Returning tag, only to the owner
    word_t    data;
  } bus_rsp_t;

endpackage

`default_nettype wire
